// File: project.f
verilog/readout_pkg.sv
verilog/generic_fifo.sv
verilog/word_decode.sv
verilog/hit_execute.sv
verilog/result_stage.sv
verilog/readout_core.sv
tb/clock_gen.sv
tb/readout_props.sv
tb/readout_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module readout_tb -o readout_tb
./obj_dir/readout_tb

// File: tb/clock_gen.sv
module clock_gen #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;   // even duty cycle
    end

endmodule

// File: tb/readout_props.sv
module readout_props #(
    parameter int out_credits = 4
) (
    input logic                               clk,
    input logic                               reset,
    input logic                               in_credit,
    input logic                               out_valid,
    input logic                               out_credit,
    input logic                               in_write,
    input logic                               in_full,
    input logic                               out_write,  // execute offers a word
    input logic                               out_full,
    input logic [readout_pkg::word_width-1:0] out_word
);

    int credits_seen;   // downstream credits as the consumer protocol counts them

    always_ff @(posedge clk) begin
        if (reset) begin
            credits_seen <= out_credits;
        end else begin
            credits_seen <= credits_seen - int'(out_valid) + int'(out_credit);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credit and FIFO rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    credit_before_send: assert property (
        @(posedge clk) disable iff (reset) out_valid |-> (credits_seen > 0)
    ) else $error("out_valid asserted with no downstream credit left");

    input_no_overflow: assert property (
        @(posedge clk) disable iff (reset) in_write |-> !in_full
    ) else $error("word written into the full input FIFO");

    // a word offered to the full output FIFO waits there for room
    output_word_held: assert property (
        @(posedge clk) disable iff (reset)
        (out_write && out_full) |=> (out_write && $stable(out_word))
    ) else $error("word offered to the full output FIFO was not held");

    // registered outputs have cleared one cycle into reset
    quiet_in_reset: assert property (
        @(posedge clk) reset |=> (!in_credit && !out_valid)
    ) else $error("in_credit or out_valid high while reset is held");

endmodule

// File: tb/readout_tb.sv
module readout_tb;

    import readout_pkg::*;

    localparam int in_depth    = 8;      // DUT defaults
    localparam int out_credits = 4;
    localparam int wait_limit  = 2000;   // cycles allowed per wait
    localparam int settle      = 16;

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    logic [word_width-1:0]    in_data;
    logic [tot_width-1:0]     tot_threshold;
    logic                     out_credit;
    logic                     in_credit;
    logic                     out_valid;
    logic [word_width-1:0]    out_data;
    logic [2:0]               out_level;      // out_depth 8

    logic [word_width-1:0]    rx_words[$];    // every word the consumer took
    logic [word_width-1:0]    exp_words[$];   // model output of the running test
    int                       pending[$];     // cycles at which credits go back
    int                       rx_base;
    int                       sent_count = 0;
    int                       credit_returns = 0;
    int                       delay_max;
    logic                     credit_hold;
    logic [trigger_width-1:0] model_trigger;

    clock_gen #(.period(4)) u_clock (.clk(clk));

    readout_core UUT (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .tot_threshold (tot_threshold),
        .out_credit    (out_credit),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_level     (out_level)
    );

    bind readout_core readout_props #(
        .out_credits (out_credits)
    ) props (
        .clk        (clk),
        .reset      (reset),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .in_write   (in_valid),
        .in_full    (u_decode.u_fifo.full),
        .out_write  (exe_valid),
        .out_full   (res_full),
        .out_word   (exe_word)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // consumer and credit monitors, sampled mid-cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : consumer
        int   cycle;
        logic hold_now;
        cycle      = 0;
        out_credit = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                pending.delete();                    // counter reloads in the DUT
            end else if (out_valid) begin
                rx_words.push_back(out_data);
                pending.push_back(cycle + 1 + int'($urandom % (delay_max + 1)));
            end
            hold_now = credit_hold;
            @(posedge clk);
            #1;
            cycle++;
            out_credit = 1'b0;
            if (!hold_now && pending.size() > 0 && pending[0] <= cycle) begin
                out_credit = 1'b1;                   // one credit per cycle at most
                pending.delete(0);
            end
        end
    end

    always @(negedge clk) begin
        if (in_credit) begin
            credit_returns = credit_returns + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic step();
        @(posedge clk);
        #1;                                          // drive point after the edge
    endtask

    task automatic fail_timeout(input string test, input string what);
        $display("%s: timed out waiting for %s", test, what);
        $display("Simulation failed");
        $fatal(1, "bounded wait expired");
    endtask

    task automatic check_value(input string test, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", test, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    // header sets the trigger, hit below threshold vanishes, others get the low trigger bits
    task automatic predict(input logic [word_width-1:0] raw);
        if (raw[word_width-1]) begin
            model_trigger = raw[trigger_width-1:0];
            exp_words.push_back(raw);
        end else if (raw[tag_width +: tot_width] >= tot_threshold) begin
            exp_words.push_back({raw[word_width-1:tag_width], model_trigger[tag_width-1:0]});
        end
    endtask

    function automatic logic [word_width-1:0] make_hit(input logic [6:0] column,
                                                       input logic [8:0] row,
                                                       input logic [3:0] tot);
        return {1'b0, column, row, tot, {tag_width{1'b0}}};
    endfunction

    task automatic send_word(input string test, input logic [word_width-1:0] word);
        int waited;
        waited = 0;
        while (sent_count - credit_returns >= in_depth) begin   // source out of credits
            step();
            waited++;
            if (waited > wait_limit) begin
                fail_timeout(test, "an input credit");
            end
        end
        in_valid = 1'b1;
        in_data  = word;
        sent_count++;
        predict(word);
        step();
        in_valid = 1'b0;
    endtask

    task automatic begin_test(input logic [tot_width-1:0] threshold, input int delay);
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        tot_threshold = threshold;
        delay_max     = delay;
        credit_hold   = 1'b0;
        repeat (16) step();
        reset         = 1'b0;
        model_trigger = '0;
        exp_words.delete();
        rx_base = rx_words.size();
    endtask

    task automatic wait_words(input string test, input int count);
        int waited;
        waited = 0;
        while (rx_words.size() - rx_base < count) begin
            step();
            waited++;
            if (waited > wait_limit) begin
                fail_timeout(test, $sformatf("%0d output words", count));
            end
        end
    endtask

    task automatic drain_and_compare(input string test);
        int waited;
        wait_words(test, exp_words.size());
        repeat (settle) step();                      // a surplus word would land here
        check_value(test, exp_words.size(), rx_words.size() - rx_base);
        foreach (exp_words[i]) begin
            check_value(test, exp_words[i], rx_words[rx_base + i]);
        end
        waited = 0;
        while (credit_returns < sent_count) begin
            step();
            waited++;
            if (waited > wait_limit) begin
                fail_timeout(test, "all input credits to come back");
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic header_passthrough();
        begin_test(4'd0, 1);
        for (int i = 0; i < 8; i++) begin
            send_word("header_passthrough", {1'b1, 31'(i * 32'h0123_4567)});
        end
        drain_and_compare("header_passthrough");
    endtask

    task automatic trigger_tagging();
        begin_test(4'd0, 2);
        for (int i = 0; i < 3; i++) begin
            send_word("trigger_tagging", make_hit(7'(i), 9'(i + 40), 4'(i + 3))); // tag 0
        end
        send_word("trigger_tagging", {1'b1, 31'h2345_6F0A});
        for (int i = 0; i < 3; i++) begin
            send_word("trigger_tagging", make_hit(7'(i + 9), 9'(i * 7), 4'(15 - i)));
        end
        send_word("trigger_tagging", {1'b1, 31'h0000_07FF});
        send_word("trigger_tagging", make_hit(7'd127, 9'd511, 4'd8));
        drain_and_compare("trigger_tagging");
    endtask

    task automatic tot_filtering();
        begin_test(4'd5, 0);
        send_word("tot_filtering", {1'b1, 31'h0000_0655});
        for (int t = 0; t < 16; t++) begin
            send_word("tot_filtering", make_hit(7'(t), 9'(3 * t), 4'(t)));
        end
        drain_and_compare("tot_filtering");
    endtask

    task automatic output_backpressure();
        begin_test(4'd0, 0);
        credit_hold = 1'b1;                          // consumer keeps every credit
        for (int i = 0; i < 6; i++) begin
            send_word("output_backpressure", {1'b1, 31'(i + 100)});
        end
        wait_words("output_backpressure", out_credits);
        repeat (settle) step();
        check_value("output_backpressure", out_credits, rx_words.size() - rx_base);
        check_value("output_backpressure", 2, 32'(out_level));
        credit_hold = 1'b0;
        drain_and_compare("output_backpressure");
    endtask

    task automatic input_credit_count();
        int first;
        begin_test(4'd0, 0);
        first = credit_returns;
        for (int i = 0; i < 20; i++) begin
            send_word("input_credit_count",
                      (i % 4 == 0) ? {1'b1, 31'(i)} : make_hit(7'(i), 9'(i), 4'(i)));
        end
        drain_and_compare("input_credit_count");
        repeat (settle) step();                      // a surplus pulse would land here
        check_value("input_credit_count", 20, credit_returns - first);
    endtask

    task automatic random_stream();
        logic [word_width-1:0] word;
        begin_test(4'($urandom % 16), 3);
        for (int i = 0; i < 200; i++) begin
            word = $urandom;
            if (!word[word_width-1]) begin
                word[tag_width-1:0] = '0;            // hits arrive untagged
            end
            send_word("random_stream", word);
            if ($urandom % 3 == 0) begin
                step();
            end
        end
        drain_and_compare("random_stream");
    endtask

    initial begin
        void'($urandom(33692));
        header_passthrough();
        trigger_tagging();
        tot_filtering();
        output_backpressure();
        input_credit_count();
        random_stream();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: verilog/generic_fifo.sv
module generic_fifo #(
    parameter int data_size = 32,
    parameter int depth     = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     write,
    input  logic                     read,
    input  logic [data_size-1:0]     data_in,
    output logic                     full,
    output logic                     empty,
    output logic [data_size-1:0]     data_out,
    output logic [$clog2(depth)-1:0] size
);

    localparam int ptr_width = $clog2(depth);
    localparam logic [ptr_width-1:0] last = ptr_width'(depth - 1);

    logic [data_size-1:0] mem [depth];
    logic [ptr_width-1:0] rd_pointer;
    logic [ptr_width-1:0] wr_pointer;
    logic [ptr_width-1:0] rd_inc;     // read pointer plus one, wrapped
    logic [ptr_width-1:0] wr_inc;     // write pointer plus one, wrapped
    logic [ptr_width-1:0] rd_next;    // head address once this cycle's pop is done
    logic                 do_read;
    logic                 do_write;

    assign do_read  = read && !empty;
    assign do_write = write && !full;

    assign rd_inc  = (rd_pointer == last) ? '0 : rd_pointer + 1'b1;
    assign wr_inc  = (wr_pointer == last) ? '0 : wr_pointer + 1'b1;
    assign rd_next = do_read ? rd_inc : rd_pointer;

    // one slot stays free so full and empty pointers differ
    assign full = (wr_inc == rd_pointer);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and empty flag
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pointer <= '0;
            wr_pointer <= '0;
            empty      <= 1'b1;
        end else begin
            rd_pointer <= rd_next;
            if (do_write) begin
                wr_pointer <= wr_inc;
            end
            if (do_read) begin
                empty <= (wr_pointer == rd_inc);    // popped the last stored entry
            end else begin
                empty <= (wr_pointer == rd_pointer); // lags a write by one cycle
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and registered head
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_pointer] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= mem[rd_next];                   // valid while empty is low
    end

    always_comb begin
        if (wr_pointer >= rd_pointer) begin
            size = wr_pointer - rd_pointer;
        end else begin
            size = ptr_width'(depth - int'(rd_pointer) + int'(wr_pointer));
        end
    end

endmodule

// File: verilog/hit_execute.sv
module hit_execute (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               dec_valid,
    input  readout_pkg::raw_word_t             dec_word,
    input  logic                               dec_is_header,
    input  logic [readout_pkg::tot_width-1:0]  tot_threshold,
    input  logic                               res_full,
    output logic                               dec_take,
    output logic                               exe_valid,
    output logic [readout_pkg::word_width-1:0] exe_word
);

    import readout_pkg::*;

    logic [tag_width-1:0] trigger_tag;   // low bits of the latest trigger number
    logic                 keep;          // word survives the tot filter
    raw_word_t            tagged_word;

    assign dec_take = dec_valid && !res_full;
    assign keep     = dec_is_header || (dec_word.hit.tot >= tot_threshold);

    always_comb begin
        tagged_word = dec_word;
        if (!dec_is_header) begin
            tagged_word.hit.tag = trigger_tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register, held while the output FIFO is full
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            trigger_tag <= '0;
            exe_valid   <= 1'b0;
        end else if (!res_full) begin
            exe_valid <= dec_take && keep;   // dropped hits are consumed silently
            if (dec_take && dec_is_header) begin
                trigger_tag <= dec_word.header.trigger[tag_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_take) begin
            exe_word <= tagged_word;
        end
    end

endmodule

// File: verilog/readout_core.sv
module readout_core #(
    parameter int in_depth    = 8,
    parameter int out_depth   = 8,
    parameter int out_credits = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  logic [readout_pkg::word_width-1:0] in_data,
    input  logic [readout_pkg::tot_width-1:0]  tot_threshold,
    input  logic                               out_credit,
    output logic                               in_credit,
    output logic                               out_valid,
    output logic [readout_pkg::word_width-1:0] out_data,
    output logic [$clog2(out_depth)-1:0]       out_level
);

    import readout_pkg::*;

    // decode to execute
    logic                  dec_valid;
    raw_word_t             dec_word;
    logic                  dec_is_header;
    logic                  dec_take;

    // execute to result
    logic                  exe_valid;
    logic [word_width-1:0] exe_word;
    logic                  res_full;

    word_decode #(
        .in_depth (in_depth)
    ) u_decode (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .dec_take      (dec_take),
        .in_credit     (in_credit),
        .dec_valid     (dec_valid),
        .dec_word      (dec_word),
        .dec_is_header (dec_is_header)
    );

    hit_execute u_execute (
        .clk           (clk),
        .reset         (reset),
        .dec_valid     (dec_valid),
        .dec_word      (dec_word),
        .dec_is_header (dec_is_header),
        .tot_threshold (tot_threshold),
        .res_full      (res_full),
        .dec_take      (dec_take),
        .exe_valid     (exe_valid),
        .exe_word      (exe_word)
    );

    result_stage #(
        .out_depth   (out_depth),
        .out_credits (out_credits)
    ) u_result (
        .clk        (clk),
        .reset      (reset),
        .exe_valid  (exe_valid),
        .exe_word   (exe_word),
        .out_credit (out_credit),
        .res_full   (res_full),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_level  (out_level)
    );

endmodule

// File: verilog/readout_pkg.sv
package readout_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raw word format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int word_width    = 32;             // one raw or result word
    localparam int trigger_width = word_width - 1; // everything below the kind bit
    localparam int column_width  = 7;
    localparam int row_width     = 9;
    localparam int tot_width     = 4;              // time over threshold
    localparam int tag_width     = 11;             // low trigger bits carried by a hit

    localparam logic kind_header = 1'b1;           // bit 31 set marks a trigger header

    // bit 31 tells which view holds, the other view is meaningless
    typedef union packed {
        struct packed {
            logic                     kind;        // 1
            logic [trigger_width-1:0] trigger;
        } header;
        struct packed {
            logic                    kind;         // 0
            logic [column_width-1:0] column;       // bits 30..24
            logic [row_width-1:0]    row;          // bits 23..15
            logic [tot_width-1:0]    tot;          // bits 14..11
            logic [tag_width-1:0]    tag;          // zero on input, filled by the core
        } hit;
    } raw_word_t;

endpackage

// File: verilog/result_stage.sv
module result_stage #(
    parameter int out_depth   = 8,
    parameter int out_credits = 4
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               exe_valid,
    input  logic [readout_pkg::word_width-1:0] exe_word,
    input  logic                               out_credit,
    output logic                               res_full,
    output logic                               out_valid,
    output logic [readout_pkg::word_width-1:0] out_data,
    output logic [$clog2(out_depth)-1:0]       out_level
);

    import readout_pkg::*;

    localparam int credit_width = $clog2(out_credits + 1);

    logic [credit_width-1:0] credit_count;  // credits held for the consumer
    logic                    fifo_empty;
    logic                    fifo_write;

    // execute holds its word while full, the write lands once room opens
    assign fifo_write = exe_valid && !res_full;
    assign out_valid  = !fifo_empty && (credit_count != '0);

    generic_fifo #(
        .data_size (word_width),
        .depth     (out_depth)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (fifo_write),
        .read     (out_valid),
        .data_in  (exe_word),
        .full     (res_full),
        .empty    (fifo_empty),
        .data_out (out_data),
        .size     (out_level)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // downstream credit counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_count <= credit_width'(out_credits);
        end else begin
            case ({out_valid, out_credit})
                2'b10:   credit_count <= credit_count - 1'b1;  // spent on a send
                2'b01:   credit_count <= credit_count + 1'b1;  // returned by consumer
                default: credit_count <= credit_count;         // both or neither
            endcase
        end
    end

endmodule

// File: verilog/word_decode.sv
module word_decode #(
    parameter int in_depth = 8
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  logic [readout_pkg::word_width-1:0] in_data,
    input  logic                               dec_take,
    output logic                               in_credit,
    output logic                               dec_valid,
    output readout_pkg::raw_word_t             dec_word,
    output logic                               dec_is_header
);

    import readout_pkg::*;

    logic fifo_empty;

    // the source only sends against credits, so the FIFO cannot overflow
    generic_fifo #(
        .data_size (word_width),
        .depth     (in_depth + 1)   // one slot stays free, room for in_depth words
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (in_valid),
        .read     (dec_take),
        .data_in  (in_data),
        .full     (),
        .empty    (fifo_empty),
        .data_out (dec_word),
        .size     ()
    );

    assign dec_valid     = !fifo_empty;
    assign dec_is_header = (dec_word.header.kind == kind_header); // kind bit is common to both views

    // one credit back to the source per popped word
    always_ff @(posedge clk) begin
        if (reset) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= dec_take;
        end
    end

endmodule
